// ==== rvPkg.sv ====
/*
 * shared types for the RV32I pipeline: word and register index types,
 * major opcodes, ALU operations, writeback selects, instruction formats
 */
package rvPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      regAddr_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opSystem = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOp_t;

    // value written back to rd
    typedef enum logic [1:0] {
        wbAlu = 2'b00,
        wbPc4 = 2'b01,
        wbImm = 2'b10
    } wbSel_t;

    // one instruction word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            regAddr_t   rd;
            opcode_t    opcode;
        } rType;
        struct packed {
            logic [11:0] imm12;
            regAddr_t    rs1;
            logic [2:0]  funct3;
            regAddr_t    rd;
            opcode_t     opcode;
        } iType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            opcode_t    opcode;
        } bType;
        struct packed {
            logic [19:0] imm31to12;
            regAddr_t    rd;
            opcode_t     opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            regAddr_t   rd;
            opcode_t    opcode;
        } jType;
    } instrWord_t;

    localparam word_t ecallWord = 32'h0000_0073;

endpackage

// ==== fetchUnit.sv ====
/*
 * program counter with redirect and freeze, fetch/decode register
 */
`timescale 1ns/1ps

module fetchUnit #(
    parameter rvPkg::word_t resetPc = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              freeze,
    input  logic              redirect,
    input  rvPkg::word_t      redirectPc,
    output rvPkg::word_t      imemAddr,
    input  rvPkg::word_t      imemData,
    output logic              fdValid,
    output rvPkg::word_t      fdPc,
    output rvPkg::instrWord_t fdInstr
);
    import rvPkg::*;

    word_t pc;

    // memory answers in the same cycle
    assign imemAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!freeze) begin
            pc <= pc + 32'd4;
        end
    end

    // wrong-path or post-halt fetch becomes a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            fdValid <= 1'b0;
        end else begin
            fdValid <= !(redirect || freeze);
        end
    end

    always_ff @(posedge clk) begin
        fdPc    <= pc;
        fdInstr <= imemData;
    end

endmodule

// ==== regFile.sv ====
/*
 * 32-entry integer register file, x0 fixed at zero, write-through read
 */
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  rvPkg::regAddr_t rdAddrA,
    input  rvPkg::regAddr_t rdAddrB,
    output rvPkg::word_t    rdDataA,
    output rvPkg::word_t    rdDataB,
    input  logic            wrEn,
    input  rvPkg::regAddr_t wrAddr,
    input  rvPkg::word_t    wrData
);
    import rvPkg::*;

    word_t regs [1:31];

    // same-cycle write wins over the stored value
    function automatic word_t readPort(input regAddr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wrEn && wrAddr == addr) begin
            value = wrData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

endmodule

// ==== decodeUnit.sv ====
/*
 * instruction decode, immediate generation, halt detection
 * and the decode/execute register
 */
`timescale 1ns/1ps

module decodeUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              fdValid,
    input  rvPkg::word_t      fdPc,
    input  rvPkg::instrWord_t fdInstr,
    input  logic              redirect,
    input  logic              freeze,
    output rvPkg::regAddr_t   rdAddrA,
    output rvPkg::regAddr_t   rdAddrB,
    input  rvPkg::word_t      rdDataA,
    input  rvPkg::word_t      rdDataB,
    output logic              decHaltReq,
    output logic              deValid,
    output rvPkg::word_t      dePc,
    output rvPkg::regAddr_t   deRs1,
    output rvPkg::regAddr_t   deRs2,
    output rvPkg::word_t      deRs1Data,
    output rvPkg::word_t      deRs2Data,
    output rvPkg::regAddr_t   deRd,
    output logic              deRegWrEn,
    output rvPkg::aluOp_t     deAluOp,
    output logic              deOpASel,
    output logic              deOpBSel,
    output rvPkg::word_t      deImm,
    output rvPkg::wbSel_t     deWbSel,
    output logic              deBranch,
    output logic              deJump,
    output logic [2:0]        deFunct3,
    output logic              deHalt
);
    import rvPkg::*;

    logic [2:0] f3;
    logic [6:0] f7;
    word_t      immI, immB, immU, immJ, imm;
    aluOp_t     aluOp;
    wbSel_t     wbSel;
    logic       opASel, opBSel, regWrEn, branch, jump;
    logic       unsupported, isHalt;

    // funct3 bit pattern to ALU operation, alt picks sub/sra
    function automatic aluOp_t aluSelect(input logic [2:0] funct3, input logic alt);
        aluOp_t op;
        case (funct3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    assign f3 = fdInstr.rType.funct3;
    assign f7 = fdInstr.rType.funct7;
    assign rdAddrA = fdInstr.rType.rs1;
    assign rdAddrB = fdInstr.rType.rs2;

    // sign-extended immediates per format
    assign immI = {{20{fdInstr.iType.imm12[11]}}, fdInstr.iType.imm12};
    assign immB = {{19{fdInstr.bType.imm12}}, fdInstr.bType.imm12, fdInstr.bType.imm11,
                   fdInstr.bType.imm10to5, fdInstr.bType.imm4to1, 1'b0};
    assign immU = {fdInstr.uType.imm31to12, 12'b0};
    assign immJ = {{11{fdInstr.jType.imm20}}, fdInstr.jType.imm20, fdInstr.jType.imm19to12,
                   fdInstr.jType.imm11, fdInstr.jType.imm10to1, 1'b0};

    always_comb begin
        aluOp       = aluAdd;
        wbSel       = wbAlu;
        opASel      = 1'b0;
        opBSel      = 1'b0;
        regWrEn     = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        unsupported = 1'b0;
        imm         = immI;
        case (fdInstr.rType.opcode)
            opOp: begin
                regWrEn = 1'b1;
                aluOp   = aluSelect(f3, f7[5]);
                if (f7 != 7'b0 && !(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))) begin
                    unsupported = 1'b1;
                end
            end
            opOpImm: begin
                regWrEn = 1'b1;
                opBSel  = 1'b1;
                aluOp   = aluSelect(f3, f3 == 3'b101 && f7[5]);
                // shift-immediate forms carry funct7 in the upper imm bits
                if (f3 == 3'b001 && f7 != 7'b0) begin
                    unsupported = 1'b1;
                end
                if (f3 == 3'b101 && f7 != 7'b0 && f7 != 7'b0100000) begin
                    unsupported = 1'b1;
                end
            end
            opLui: begin
                regWrEn = 1'b1;
                wbSel   = wbImm;
                imm     = immU;
            end
            opAuipc: begin
                regWrEn = 1'b1;
                opASel  = 1'b1;
                opBSel  = 1'b1;
                imm     = immU;
            end
            opBranch: begin
                branch      = 1'b1;
                imm         = immB;
                unsupported = (f3[2:1] == 2'b01);
            end
            opJal: begin
                jump    = 1'b1;
                regWrEn = 1'b1;
                wbSel   = wbPc4;
                imm     = immJ;
            end
            opSystem: begin
                // only ecall is known here
                unsupported = (fdInstr != ecallWord);
            end
            default: unsupported = 1'b1;
        endcase
    end

    assign isHalt     = unsupported || (fdInstr == ecallWord);
    assign decHaltReq = fdValid && isHalt;

    always_ff @(posedge clk) begin
        if (rst) begin
            deValid <= 1'b0;
        end else begin
            deValid <= fdValid && !redirect && !freeze;
        end
    end

    always_ff @(posedge clk) begin
        dePc      <= fdPc;
        deRs1     <= rdAddrA;
        deRs2     <= rdAddrB;
        deRs1Data <= rdDataA;
        deRs2Data <= rdDataB;
        deRd      <= fdInstr.rType.rd;
        deRegWrEn <= regWrEn && !isHalt;
        deAluOp   <= aluOp;
        deOpASel  <= opASel;
        deOpBSel  <= opBSel;
        deImm     <= imm;
        deWbSel   <= wbSel;
        deBranch  <= branch && !isHalt;
        deJump    <= jump;
        deFunct3  <= f3;
        deHalt    <= isHalt;
    end

endmodule

// ==== executeUnit.sv ====
/*
 * operand forwarding, ALU, branch compare, target alignment check
 * and the execute/writeback register
 */
`timescale 1ns/1ps

module executeUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            deValid,
    input  rvPkg::word_t    dePc,
    input  rvPkg::regAddr_t deRs1,
    input  rvPkg::regAddr_t deRs2,
    input  rvPkg::word_t    deRs1Data,
    input  rvPkg::word_t    deRs2Data,
    input  rvPkg::regAddr_t deRd,
    input  logic            deRegWrEn,
    input  rvPkg::aluOp_t   deAluOp,
    input  logic            deOpASel,
    input  logic            deOpBSel,
    input  rvPkg::word_t    deImm,
    input  rvPkg::wbSel_t   deWbSel,
    input  logic            deBranch,
    input  logic            deJump,
    input  logic [2:0]      deFunct3,
    input  logic            deHalt,
    output logic            redirect,
    output rvPkg::word_t    redirectPc,
    output logic            exHaltReq,
    output logic            wbValid,
    output rvPkg::regAddr_t wbRd,
    output rvPkg::word_t    wbData,
    output logic            wbHalt
);
    import rvPkg::*;

    logic  live, branchCond, taken, misaligned;
    word_t fwdA, fwdB, opA, opB;
    word_t aluResult, target, pcPlus4, result;

    // anything behind a halting instruction is dropped
    assign live = deValid && !wbHalt;

    // previous instruction's result lives in the writeback register
    assign fwdA = (wbValid && wbRd != '0 && wbRd == deRs1) ? wbData : deRs1Data;
    assign fwdB = (wbValid && wbRd != '0 && wbRd == deRs2) ? wbData : deRs2Data;

    assign opA = deOpASel ? dePc : fwdA;
    assign opB = deOpBSel ? deImm : fwdB;

    always_comb begin
        case (deAluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluSll:  aluResult = opA << opB[4:0];
            aluSlt:  aluResult = word_t'($signed(opA) < $signed(opB));
            aluSltu: aluResult = word_t'(opA < opB);
            aluXor:  aluResult = opA ^ opB;
            aluSrl:  aluResult = opA >> opB[4:0];
            aluSra:  aluResult = $signed(opA) >>> opB[4:0];
            aluOr:   aluResult = opA | opB;
            aluAnd:  aluResult = opA & opB;
            default: aluResult = '0;
        endcase
    end

    // branch condition under funct3
    always_comb begin
        case (deFunct3)
            3'b000:  branchCond = (fwdA == fwdB);
            3'b001:  branchCond = (fwdA != fwdB);
            3'b100:  branchCond = ($signed(fwdA) < $signed(fwdB));
            3'b101:  branchCond = ($signed(fwdA) >= $signed(fwdB));
            3'b110:  branchCond = (fwdA < fwdB);
            3'b111:  branchCond = (fwdA >= fwdB);
            default: branchCond = 1'b0;
        endcase
    end

    assign target     = dePc + deImm;
    assign pcPlus4    = dePc + 32'd4;
    assign taken      = live && (deJump || (deBranch && branchCond));
    assign misaligned = (target[1:0] != 2'b00);

    // misaligned target halts instead of redirecting
    assign redirect   = taken && !misaligned;
    assign redirectPc = target;
    assign exHaltReq  = taken && misaligned;

    always_comb begin
        case (deWbSel)
            wbPc4:   result = pcPlus4;
            wbImm:   result = deImm;
            default: result = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
            wbHalt  <= 1'b0;
        end else begin
            wbValid <= live && deRegWrEn && !exHaltReq;
            wbHalt  <= live && (deHalt || exHaltReq);
        end
    end

    always_ff @(posedge clk) begin
        wbRd   <= deRd;
        wbData <= result;
    end

endmodule

// ==== haltController.sv ====
/*
 * run/drain/halted FSM driving fetch freeze and the halt output
 */
`timescale 1ns/1ps

module haltController (
    input  logic clk,
    input  logic rst,
    input  logic decHaltReq,
    input  logic exHaltReq,
    input  logic redirect,
    input  logic wbHalt,
    output logic freeze,
    output logic halt
);

    typedef enum logic [1:0] {
        stateRunning,
        stateDraining,
        stateHalted
    } haltState_t;

    haltState_t state, nextState;

    always_comb begin
        nextState = state;
        case (state)
            stateRunning: begin
                // a decode request on the wrong path is ignored
                if (wbHalt) begin
                    nextState = stateHalted;
                end else if ((decHaltReq && !redirect) || exHaltReq) begin
                    nextState = stateDraining;
                end
            end
            stateDraining: begin
                if (wbHalt) begin
                    nextState = stateHalted;
                end
            end
            default: nextState = stateHalted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stateRunning;
        end else begin
            state <= nextState;
        end
    end

    assign freeze = (state != stateRunning);
    assign halt   = (state == stateHalted);

endmodule

// ==== rvPipeline.sv ====
/*
 * four-stage RV32I pipeline top with instruction memory and commit ports
 */
`timescale 1ns/1ps

module rvPipeline #(
    parameter rvPkg::word_t resetPc = '0
) (
    input  logic            clk,
    input  logic            rst,
    output rvPkg::word_t    imemAddr,
    input  rvPkg::word_t    imemData,
    output logic            commitValid,
    output rvPkg::regAddr_t commitRd,
    output rvPkg::word_t    commitData,
    output logic            halt
);
    import rvPkg::*;

    logic       fdValid, deValid, deRegWrEn, deOpASel, deOpBSel;
    logic       deBranch, deJump, deHalt, decHaltReq, exHaltReq;
    logic       redirect, freeze, wbValid, wbHalt;
    logic [2:0] deFunct3;
    word_t      fdPc, dePc, deImm, deRs1Data, deRs2Data, rdDataA, rdDataB;
    word_t      redirectPc, wbData;
    regAddr_t   rdAddrA, rdAddrB, deRs1, deRs2, deRd, wbRd;
    instrWord_t fdInstr;
    aluOp_t     deAluOp;
    wbSel_t     deWbSel;

    fetchUnit #(.resetPc(resetPc)) i_fetchUnit (
        .clk(clk), .rst(rst), .freeze(freeze), .redirect(redirect),
        .redirectPc(redirectPc), .imemAddr(imemAddr), .imemData(imemData),
        .fdValid(fdValid), .fdPc(fdPc), .fdInstr(fdInstr)
    );

    regFile i_regFile (
        .clk(clk), .rst(rst), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wbValid), .wrAddr(wbRd), .wrData(wbData)
    );

    decodeUnit i_decodeUnit (
        .clk(clk), .rst(rst), .fdValid(fdValid), .fdPc(fdPc), .fdInstr(fdInstr),
        .redirect(redirect), .freeze(freeze), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .rdDataA(rdDataA), .rdDataB(rdDataB), .decHaltReq(decHaltReq),
        .deValid(deValid), .dePc(dePc), .deRs1(deRs1), .deRs2(deRs2),
        .deRs1Data(deRs1Data), .deRs2Data(deRs2Data), .deRd(deRd),
        .deRegWrEn(deRegWrEn), .deAluOp(deAluOp), .deOpASel(deOpASel),
        .deOpBSel(deOpBSel), .deImm(deImm), .deWbSel(deWbSel), .deBranch(deBranch),
        .deJump(deJump), .deFunct3(deFunct3), .deHalt(deHalt)
    );

    executeUnit i_executeUnit (
        .clk(clk), .rst(rst), .deValid(deValid), .dePc(dePc), .deRs1(deRs1),
        .deRs2(deRs2), .deRs1Data(deRs1Data), .deRs2Data(deRs2Data), .deRd(deRd),
        .deRegWrEn(deRegWrEn), .deAluOp(deAluOp), .deOpASel(deOpASel),
        .deOpBSel(deOpBSel), .deImm(deImm), .deWbSel(deWbSel), .deBranch(deBranch),
        .deJump(deJump), .deFunct3(deFunct3), .deHalt(deHalt),
        .redirect(redirect), .redirectPc(redirectPc), .exHaltReq(exHaltReq),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData), .wbHalt(wbHalt)
    );

    haltController i_haltController (
        .clk(clk), .rst(rst), .decHaltReq(decHaltReq), .exHaltReq(exHaltReq),
        .redirect(redirect), .wbHalt(wbHalt), .freeze(freeze), .halt(halt)
    );

    // writes to x0 retire silently
    assign commitValid = wbValid && (wbRd != '0);
    assign commitRd    = wbRd;
    assign commitData  = wbData;

endmodule

// ==== tbProgramTable.svh ====
/*
 * test program table with one row per instruction word {program, word},
 * one row per expected commit {program, rd, value} and the program names
 */

localparam int programCount = 5;
localparam int instrCount   = 72;
localparam int commitCount  = 44;

localparam string programName [programCount] = '{
    "aluChain", "branches", "jalLuiAuipc", "badOpcode", "misalignedBranch"
};

// {program, instruction word}
localparam logic [39:0] instrRows [instrCount] = '{
    // register and immediate arithmetic chain
    {8'd0, 32'h00500093}, {8'd0, 32'hFFD08113}, {8'd0, 32'h001101B3},
    {8'd0, 32'h40118233}, {8'd0, 32'h004192B3}, {8'd0, 32'hFF800313},
    {8'd0, 32'h005323B3}, {8'd0, 32'h00533433}, {8'd0, 32'h005344B3},
    {8'd0, 32'h0074D533}, {8'd0, 32'h4074D5B3}, {8'd0, 32'h0055E633},
    {8'd0, 32'h00A676B3}, {8'd0, 32'hFFF6A713}, {8'd0, 32'hFFF6B793},
    {8'd0, 32'hFFF7C813}, {8'd0, 32'h40485893}, {8'd0, 32'h01C8D913},
    {8'd0, 32'h00891993}, {8'd0, 32'h00A9EA13}, {8'd0, 32'h0FFA7A93},
    // all six branch kinds taken and not taken
    // skipped slots write x31
    {8'd1, 32'h00500093}, {8'd1, 32'hFFD00113}, {8'd1, 32'h00208463},
    {8'd1, 32'h00100193}, {8'd1, 32'h00209463}, {8'd1, 32'hFFF00F93},
    {8'd1, 32'h00200213}, {8'd1, 32'h00114463}, {8'd1, 32'hFFF00F93},
    {8'd1, 32'h00300293}, {8'd1, 32'h00115463}, {8'd1, 32'h00400313},
    {8'd1, 32'h00116463}, {8'd1, 32'h00500393}, {8'd1, 32'h00117463},
    {8'd1, 32'hFFF00F93}, {8'd1, 32'h00600413}, {8'd1, 32'h00108463},
    {8'd1, 32'hFFF00F93}, {8'd1, 32'h0020E463}, {8'd1, 32'hFFF00F93},
    {8'd1, 32'h00700493}, {8'd1, 32'h00109463}, {8'd1, 32'h00800513},
    {8'd1, 32'h0020C463}, {8'd1, 32'h00900593}, {8'd1, 32'h0020D463},
    {8'd1, 32'hFFF00F93}, {8'd1, 32'h00A00613}, {8'd1, 32'h0020F463},
    {8'd1, 32'h00B00693},
    // upper immediates and jal ending in ecall with a live slot behind it
    {8'd2, 32'h123450B7}, {8'd2, 32'h00001117}, {8'd2, 32'h00C001EF},
    {8'd2, 32'hFFF00F93}, {8'd2, 32'hFFF00F93}, {8'd2, 32'h00118213},
    {8'd2, 32'hFFFFF2B7}, {8'd2, 32'h00000317}, {8'd2, 32'h0080006F},
    {8'd2, 32'hFFF00F93}, {8'd2, 32'h005303B3}, {8'd2, 32'h00000073},
    {8'd2, 32'hFFF00F93},
    // custom-0 opcode halts
    {8'd3, 32'h00900093}, {8'd3, 32'h00108113}, {8'd3, 32'h0000000B},
    {8'd3, 32'h00100193},
    // beq to pc+6
    {8'd4, 32'h00100093}, {8'd4, 32'h00000363}, {8'd4, 32'h00200113}
};

// {program, rd, value}
localparam logic [44:0] commitRows [commitCount] = '{
    {8'd0, 5'd1, 32'h00000005}, {8'd0, 5'd2, 32'h00000002}, {8'd0, 5'd3, 32'h00000007},
    {8'd0, 5'd4, 32'h00000002}, {8'd0, 5'd5, 32'h0000001C}, {8'd0, 5'd6, 32'hFFFFFFF8},
    {8'd0, 5'd7, 32'h00000001}, {8'd0, 5'd8, 32'h00000000}, {8'd0, 5'd9, 32'hFFFFFFE4},
    {8'd0, 5'd10, 32'h7FFFFFF2}, {8'd0, 5'd11, 32'hFFFFFFF2}, {8'd0, 5'd12, 32'hFFFFFFFE},
    {8'd0, 5'd13, 32'h7FFFFFF2}, {8'd0, 5'd14, 32'h00000000}, {8'd0, 5'd15, 32'h00000001},
    {8'd0, 5'd16, 32'hFFFFFFFE}, {8'd0, 5'd17, 32'hFFFFFFFF}, {8'd0, 5'd18, 32'h0000000F},
    {8'd0, 5'd19, 32'h00000F00}, {8'd0, 5'd20, 32'h00000F0A}, {8'd0, 5'd21, 32'h0000000A},
    {8'd1, 5'd1, 32'h00000005}, {8'd1, 5'd2, 32'hFFFFFFFD}, {8'd1, 5'd3, 32'h00000001},
    {8'd1, 5'd4, 32'h00000002}, {8'd1, 5'd5, 32'h00000003}, {8'd1, 5'd6, 32'h00000004},
    {8'd1, 5'd7, 32'h00000005}, {8'd1, 5'd8, 32'h00000006}, {8'd1, 5'd9, 32'h00000007},
    {8'd1, 5'd10, 32'h00000008}, {8'd1, 5'd11, 32'h00000009}, {8'd1, 5'd12, 32'h0000000A},
    {8'd1, 5'd13, 32'h0000000B},
    {8'd2, 5'd1, 32'h12345000}, {8'd2, 5'd2, 32'h00001004}, {8'd2, 5'd3, 32'h0000000C},
    {8'd2, 5'd4, 32'h0000000D}, {8'd2, 5'd5, 32'hFFFFF000}, {8'd2, 5'd6, 32'h0000001C},
    {8'd2, 5'd7, 32'hFFFFF01C},
    {8'd3, 5'd1, 32'h00000009}, {8'd3, 5'd2, 32'h0000000A},
    {8'd4, 5'd1, 32'h00000001}
};

// ==== tbRvPipeline.sv ====
/*
 * RV32I pipeline testbench with clock, reset, instruction memory model,
 * program loop with commit checks and halt checks
 */
`timescale 1ns/1ps

module tbRvPipeline;
    import rvPkg::*;

    logic     clk;
    logic     rst;
    word_t    imemAddr;
    word_t    imemData;
    logic     commitValid;
    regAddr_t commitRd;
    word_t    commitData;
    logic     halt;

    word_t    imem [0:63];
    regAddr_t expRd [$];
    word_t    expData [$];

    `include "tbProgramTable.svh"

    rvPipeline #(.resetPc(32'h0)) i_rvPipeline (
        .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
        .commitValid(commitValid), .commitRd(commitRd), .commitData(commitData),
        .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory answers on the falling edge
    // ecall outside the array
    always @(negedge clk) begin
        if (imemAddr < 32'd256) begin
            imemData <= imem[imemAddr[7:2]];
        end else begin
            imemData <= ecallWord;
        end
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkReg(input string name, input int idx, input regAddr_t expected,
                            input regAddr_t actual);
        if (expected !== actual) begin
            $display("error %s commit %0d rd: expected %0d actual %0d",
                     name, idx, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic checkWord(input string name, input int idx, input word_t expected,
                             input word_t actual);
        if (expected !== actual) begin
            $display("error %s commit %0d data: expected %h actual %h",
                     name, idx, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // memory image and expected commits of one program
    task automatic loadProgram(input int prog);
        int n;
        n = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = ecallWord;
        end
        for (int i = 0; i < instrCount; i++) begin
            if (int'(instrRows[i][39:32]) == prog) begin
                imem[n] = instrRows[i][31:0];
                n++;
            end
        end
        expRd.delete();
        expData.delete();
        for (int i = 0; i < commitCount; i++) begin
            if (int'(commitRows[i][44:37]) == prog) begin
                expRd.push_back(commitRows[i][36:32]);
                expData.push_back(commitRows[i][31:0]);
            end
        end
    endtask

    task automatic runProgram(input int prog);
        string name;
        int    cycles;
        int    seen;
        name = programName[prog];
        loadProgram(prog);
        @(negedge clk);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        if (halt !== 1'b0 || commitValid !== 1'b0) begin
            failRun($sformatf("%s: halt or commit active right after reset", name));
        end
        cycles = 0;
        seen   = 0;
        while (!halt) begin
            @(negedge clk);
            cycles++;
            if (cycles > 300) begin
                failRun($sformatf("%s: timeout waiting for halt", name));
            end
            if (commitValid) begin
                if (seen >= expRd.size()) begin
                    failRun($sformatf("%s: extra commit to x%0d", name, commitRd));
                end
                checkReg(name, seen, expRd[seen], commitRd);
                checkWord(name, seen, expData[seen], commitData);
                seen++;
            end
        end
        if (seen != expRd.size()) begin
            failRun($sformatf("%s: only %0d of %0d commits seen before halt",
                              name, seen, expRd.size()));
        end
        // halt must hold with a quiet commit port
        repeat (10) begin
            @(negedge clk);
            if (!halt) begin
                failRun($sformatf("%s: halt dropped before reset", name));
            end
            if (commitValid) begin
                failRun($sformatf("%s: commit after halt", name));
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        imemData = ecallWord;
        for (int i = 0; i < 64; i++) begin
            imem[i] = ecallWord;
        end
        for (int p = 0; p < programCount; p++) begin
            runProgram(p);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== rvPipeline.f ====
rvPkg.sv
fetchUnit.sv
regFile.sv
decodeUnit.sv
executeUnit.sv
haltController.sv
rvPipeline.sv
tbRvPipeline.sv

// ==== run.sh ====
#!/bin/bash
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rvPipeline.f --top-module tbRvPipeline -o simTb || exit 1
./obj_dir/simTb > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1
